/* common/dmm_tx_pkg.sv */
`default_nettype none

package dmm_tx_pkg;

    //------------------------------------------------------------
    // widths
    //------------------------------------------------------------
    typedef logic [17:0] word_t;      // [17] header start, [16] end marker
    typedef logic [9:0]  addr_t;      // frame ram address
    typedef logic [4:0]  chn_type_t;
    typedef logic [2:0]  reg_off_t;   // apb word offset
    typedef logic [15:0] apb_data_t;
    typedef logic [31:0] slot_t;      // resend slot in clocks

    // channel type codes, anything else is an i/o channel
    localparam chn_type_t COM2_TYPE = 5'd2;
    localparam chn_type_t COM3_TYPE = 5'd3;
    localparam chn_type_t MPU_TYPE  = 5'd4;

    //------------------------------------------------------------
    // frame constants
    //------------------------------------------------------------
    localparam logic [15:0] COM_DATA_LEN   = 16'd256;
    localparam logic [15:0] IO_DATA_LEN    = 16'd64;
    localparam logic [15:0] HDR_OVERHEAD   = 16'd8;
    localparam logic [15:0] DATA_TYPE_WORD = 16'h0800;
    localparam int          HDR_WORDS      = 7;   // header words ahead of payload
    localparam int          RESEND_MAX     = 2;

    typedef struct packed {
        logic [15:0] run_cycle;
        logic [7:0]  dst_sta_num;
        logic [2:0]  dst_port0;
        logic [2:0]  dst_port1;
        logic [7:0]  master_slave_flag;
        chn_type_t   chn_type;
    } cfg_t;

    typedef struct packed {
        logic  wr_sel;    // frame envelope
        logic  port_sel;  // target channel
        logic  wr_en;
        word_t wr_data;
    } wr_port_t;

    typedef enum logic [2:0] {
        RUN_CYCLE = 3'd0,
        STA_NUM   = 3'd1,
        DST_PORTS = 3'd2,
        MS_FLAG   = 3'd3,
        CHN_TYPE  = 3'd4
    } reg_addr_e;

    typedef enum logic [1:0] {IDLE, HEADER, PAYLOAD} rd_state_e;

endpackage

`default_nettype wire

/* source/dmm_cfg_regs.sv */
`default_nettype none

module dmm_cfg_regs (
    input  logic                  clk_12_5m,
    input  logic                  rst_12_5m,
    input  dmm_tx_pkg::reg_off_t  paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  dmm_tx_pkg::apb_data_t pwdata,
    output dmm_tx_pkg::apb_data_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    output dmm_tx_pkg::cfg_t      cfg
);

    dmm_tx_pkg::cfg_t cfg_q;
    logic             access;   // apb access phase
    logic             hit;      // offset is mapped

    assign access  = psel & penable;
    assign pready  = 1'b1;              // zero wait states
    assign pslverr = access & ~hit;
    assign cfg     = cfg_q;

    // read mux and address decode
    always_comb begin
        hit    = 1'b1;
        prdata = '0;
        case (paddr)
            dmm_tx_pkg::RUN_CYCLE: prdata = cfg_q.run_cycle;
            dmm_tx_pkg::STA_NUM:   prdata = {8'd0, cfg_q.dst_sta_num};
            dmm_tx_pkg::DST_PORTS: prdata = {9'd0, cfg_q.dst_port1, 1'b0, cfg_q.dst_port0};
            dmm_tx_pkg::MS_FLAG:   prdata = {8'd0, cfg_q.master_slave_flag};
            dmm_tx_pkg::CHN_TYPE:  prdata = {11'd0, cfg_q.chn_type};
            default:               hit    = 1'b0;   // unmapped
        endcase
    end

    //------------------------------------------------------------
    // register writes, taken in the access phase
    //------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            cfg_q <= '0;
        end else if (access && pwrite && hit) begin
            case (paddr)
                dmm_tx_pkg::RUN_CYCLE: cfg_q.run_cycle   <= pwdata;
                dmm_tx_pkg::STA_NUM:   cfg_q.dst_sta_num <= pwdata[7:0];
                dmm_tx_pkg::DST_PORTS: begin
                    cfg_q.dst_port0 <= pwdata[2:0];   // chn 0
                    cfg_q.dst_port1 <= pwdata[6:4];   // chn 1
                end
                dmm_tx_pkg::MS_FLAG:   cfg_q.master_slave_flag <= pwdata[7:0];
                dmm_tx_pkg::CHN_TYPE:  cfg_q.chn_type          <= pwdata[4:0];
                default: ;
            endcase
        end
    end

    // bus master must hold psel through the access phase
    a_penable_in_psel : assert property (
        @(posedge clk_12_5m) disable iff (!rst_12_5m)
        penable |-> psel
    );

endmodule

`default_nettype wire

/* buffer/dmm_buffer_writer.sv */
`default_nettype none

module dmm_buffer_writer #(
    parameter dmm_tx_pkg::addr_t BASE0_ADDR = 10'd0,
    parameter dmm_tx_pkg::addr_t BASE1_ADDR = 10'd512
) (
    input  logic                 clk_12_5m,
    input  logic                 rst_12_5m,
    input  dmm_tx_pkg::wr_port_t wr_port,
    output logic                 ram_we,
    output dmm_tx_pkg::addr_t    ram_waddr,
    output dmm_tx_pkg::word_t    ram_wdata,
    output logic [1:0]           wr_finish
);

    logic              sel_d1;       // wr_sel last cycle
    logic              chn_q;        // channel of current frame
    logic              frame_start;
    logic              frame_end;
    logic              wr_go;        // word accepted this cycle
    dmm_tx_pkg::addr_t wr_ptr;
    dmm_tx_pkg::addr_t cur_addr;

    assign frame_start = wr_port.wr_sel & ~sel_d1;
    assign frame_end   = ~wr_port.wr_sel & sel_d1;
    assign wr_go       = wr_port.wr_sel & wr_port.wr_en;

    // first cycle of a frame writes straight at the channel base
    assign cur_addr = frame_start ? (wr_port.port_sel ? BASE1_ADDR : BASE0_ADDR) : wr_ptr;

    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            sel_d1    <= 1'b0;
            chn_q     <= 1'b0;
            wr_ptr    <= '0;
            ram_we    <= 1'b0;
            wr_finish <= 2'b00;
        end else begin
            sel_d1 <= wr_port.wr_sel;
            ram_we <= wr_go;
            if (frame_start) chn_q <= wr_port.port_sel;
            if (wr_go) begin
                wr_ptr <= cur_addr + 1'b1;   // step after each word
            end else if (frame_start) begin
                wr_ptr <= cur_addr;
            end
            // one pulse per frame, on the stored channel
            wr_finish <= frame_end ? (chn_q ? 2'b10 : 2'b01) : 2'b00;
        end
    end

    // write data path, one stage behind the port
    always_ff @(posedge clk_12_5m) begin
        ram_waddr <= cur_addr;
        ram_wdata <= wr_port.wr_data;
    end

    // a frame belongs to one channel only
    a_port_steady : assert property (
        @(posedge clk_12_5m) disable iff (!rst_12_5m)
        (wr_port.wr_sel && sel_d1) |-> $stable(wr_port.port_sel)
    );

endmodule

`default_nettype wire

/* buffer/dmm_frame_ram.sv */
`default_nettype none

module dmm_frame_ram (
    input  logic              clk_12_5m,
    input  logic              we,
    input  dmm_tx_pkg::addr_t waddr,
    input  dmm_tx_pkg::word_t wdata,
    input  dmm_tx_pkg::addr_t raddr,
    output dmm_tx_pkg::word_t rdata
);

    localparam int DEPTH = 2 ** $bits(dmm_tx_pkg::addr_t);   // both channel buffers

    dmm_tx_pkg::word_t mem [0:DEPTH-1];

    // write port, host side
    always_ff @(posedge clk_12_5m) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, registered, one cycle latency
    always_ff @(posedge clk_12_5m) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* framer/dmm_frame_reader.sv */
`default_nettype none

module dmm_frame_reader #(
    parameter dmm_tx_pkg::addr_t BASE0_ADDR = 10'd0,
    parameter dmm_tx_pkg::addr_t BASE1_ADDR = 10'd512
) (
    input  logic              clk_12_5m,
    input  logic              rst_12_5m,
    input  dmm_tx_pkg::cfg_t  cfg,
    input  logic [1:0]        rd_en,
    input  dmm_tx_pkg::word_t rdata,
    output dmm_tx_pkg::addr_t raddr,
    output logic [1:0]        tx_dval,
    output dmm_tx_pkg::word_t tx_data,
    output logic [1:0]        frame_done
);

    dmm_tx_pkg::rd_state_e state;
    logic [2:0]            hdr_cnt;    // word index, parks at 7 in payload
    logic                  rd_any;
    logic [2:0]            port;       // dest port of active channel
    logic [15:0]           pkt_len;
    dmm_tx_pkg::word_t     hdr_word;
    dmm_tx_pkg::addr_t     rd_ptr;     // next address to fetch

    assign rd_any = |rd_en;
    assign port   = rd_en[1] ? cfg.dst_port1 : cfg.dst_port0;

    // while paused re-read the word that is still owed
    assign raddr = rd_any ? rd_ptr : dmm_tx_pkg::addr_t'(rd_ptr - 1'b1);

    always_comb begin
        case (cfg.chn_type)
            dmm_tx_pkg::COM2_TYPE,
            dmm_tx_pkg::COM3_TYPE,
            dmm_tx_pkg::MPU_TYPE: pkt_len = dmm_tx_pkg::COM_DATA_LEN - dmm_tx_pkg::HDR_OVERHEAD;
            default:              pkt_len = dmm_tx_pkg::IO_DATA_LEN - dmm_tx_pkg::HDR_OVERHEAD;
        endcase
    end

    //------------------------------------------------------------
    // header words
    //------------------------------------------------------------
    always_comb begin
        case (hdr_cnt)
            3'd0:    hdr_word = {2'b10, 6'd0, cfg.dst_sta_num, port[2:1]};       // da
            3'd1:    hdr_word = {2'b00, port[0], 12'd0, cfg.master_slave_flag[0], 2'd0};
            3'd3:    hdr_word = {2'b00, cfg.run_cycle};
            3'd4:    hdr_word = {2'b00, dmm_tx_pkg::DATA_TYPE_WORD};
            3'd6:    hdr_word = {2'b00, pkt_len};
            default: hdr_word = '0;    // sa and tick slot
        endcase
    end

    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            state      <= dmm_tx_pkg::IDLE;
            hdr_cnt    <= '0;
            rd_ptr     <= '0;
            tx_dval    <= 2'b00;
            tx_data    <= '0;
            frame_done <= 2'b00;
        end else begin
            tx_dval    <= rd_en;
            frame_done <= 2'b00;
            if (rd_any) begin
                case (state)
                    dmm_tx_pkg::PAYLOAD: begin
                        tx_data <= {1'b0, rdata[16:0]};   // strip start flag
                        if (rdata[16]) begin
                            frame_done <= rd_en;
                            state      <= dmm_tx_pkg::IDLE;
                            hdr_cnt    <= '0;
                        end
                    end
                    default: begin                        // idle or header
                        tx_data <= hdr_word;
                        hdr_cnt <= hdr_cnt + 1'b1;
                        if (hdr_cnt == 3'(dmm_tx_pkg::HDR_WORDS - 1)) begin
                            state <= dmm_tx_pkg::PAYLOAD;
                        end else begin
                            state <= dmm_tx_pkg::HEADER;
                        end
                    end
                endcase
                // base in word 5 so payload lands at word 7
                if (hdr_cnt == 3'd5) begin
                    rd_ptr <= rd_en[1] ? BASE1_ADDR : BASE0_ADDR;
                end else if (hdr_cnt >= 3'd6) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // one channel read at a time
    a_rd_en_onehot : assert property (
        @(posedge clk_12_5m) disable iff (!rst_12_5m)
        $onehot0(rd_en)
    );

endmodule

`default_nettype wire

/* framer/dmm_ready_tracker.sv */
`default_nettype none

module dmm_ready_tracker #(
    parameter int unsigned SLOT_MULT     = 5120,
    parameter int unsigned DEFAULT_SLOT  = 162500,
    parameter int unsigned MIN_RUN_CYCLE = 30
) (
    input  logic             clk_12_5m,
    input  logic             rst_12_5m,
    input  dmm_tx_pkg::cfg_t cfg,
    input  logic [1:0]       wr_finish,
    input  logic [1:0]       frame_done,
    output logic [1:0]       dmm_empty
);

    dmm_tx_pkg::slot_t slot;
    logic              is_com3;    // com3 frames are never offered again

    assign is_com3 = (cfg.chn_type == dmm_tx_pkg::COM3_TYPE);

    // slot length from run cycle, fallback for short cycles
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            slot <= DEFAULT_SLOT;
        end else if (cfg.run_cycle > MIN_RUN_CYCLE) begin
            slot <= dmm_tx_pkg::slot_t'(cfg.run_cycle) * dmm_tx_pkg::slot_t'(SLOT_MULT);
        end else begin
            slot <= DEFAULT_SLOT;
        end
    end

    //------------------------------------------------------------
    // per channel flag, timer and resend count
    //------------------------------------------------------------
    for (genvar i = 0; i < 2; i++) begin : g_chn
        dmm_tx_pkg::slot_t timer;        // 0 means idle
        logic [1:0]        resend_cnt;
        logic              expire;
        logic              empty_q;

        assign expire       = (timer == dmm_tx_pkg::slot_t'(1));
        assign dmm_empty[i] = empty_q;

        always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
            if (!rst_12_5m) begin
                timer      <= '0;
                resend_cnt <= '0;
                empty_q    <= 1'b1;
            end else begin
                if (wr_finish[i]) begin
                    timer      <= slot;
                    resend_cnt <= '0;
                end else if (expire) begin
                    resend_cnt <= resend_cnt + 1'b1;
                    // re-arm only while resends remain
                    if (resend_cnt + 1 < dmm_tx_pkg::RESEND_MAX) begin
                        timer <= slot;
                    end else begin
                        timer <= '0;
                    end
                end else if (timer != '0) begin
                    timer <= timer - 1'b1;
                end

                if (wr_finish[i]) begin
                    empty_q <= 1'b0;               // new frame ready
                end else if (frame_done[i]) begin
                    empty_q <= 1'b1;               // sent
                end else if (expire && !is_com3) begin
                    empty_q <= 1'b0;               // offer again
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/dmm_tx_top.sv */
`default_nettype none

module dmm_tx_top #(
    parameter dmm_tx_pkg::addr_t BASE0_ADDR    = 10'd0,
    parameter dmm_tx_pkg::addr_t BASE1_ADDR    = 10'd512,
    parameter int unsigned       SLOT_MULT     = 5120,
    parameter int unsigned       DEFAULT_SLOT  = 162500,
    parameter int unsigned       MIN_RUN_CYCLE = 30
) (
    input  logic                  clk_12_5m,
    input  logic                  rst_12_5m,
    // apb config
    input  dmm_tx_pkg::reg_off_t  paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  dmm_tx_pkg::apb_data_t pwdata,
    output dmm_tx_pkg::apb_data_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    // host write port
    input  dmm_tx_pkg::wr_port_t  wr_port,
    // stream side
    input  logic [1:0]            rd_en,
    output logic [1:0]            tx_dval,
    output dmm_tx_pkg::word_t     tx_data,
    output logic [1:0]            dmm_empty
);

    dmm_tx_pkg::cfg_t  cfg;
    logic              ram_we;
    dmm_tx_pkg::addr_t ram_waddr;
    dmm_tx_pkg::word_t ram_wdata;
    dmm_tx_pkg::addr_t ram_raddr;
    dmm_tx_pkg::word_t ram_rdata;
    logic [1:0]        wr_finish;   // per channel, frame stored
    logic [1:0]        frame_done;  // per channel, marker sent

    //------------------------------------------------------------
    // decode
    //------------------------------------------------------------
    dmm_cfg_regs u_cfg_regs (
        .clk_12_5m (clk_12_5m),
        .rst_12_5m (rst_12_5m),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cfg       (cfg)
    );

    //------------------------------------------------------------
    // execute
    //------------------------------------------------------------
    dmm_buffer_writer #(
        .BASE0_ADDR (BASE0_ADDR),
        .BASE1_ADDR (BASE1_ADDR)
    ) u_writer (
        .clk_12_5m (clk_12_5m),
        .rst_12_5m (rst_12_5m),
        .wr_port   (wr_port),
        .ram_we    (ram_we),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata),
        .wr_finish (wr_finish)
    );

    dmm_frame_ram u_ram (
        .clk_12_5m (clk_12_5m),
        .we        (ram_we),
        .waddr     (ram_waddr),
        .wdata     (ram_wdata),
        .raddr     (ram_raddr),
        .rdata     (ram_rdata)
    );

    //------------------------------------------------------------
    // result
    //------------------------------------------------------------
    dmm_frame_reader #(
        .BASE0_ADDR (BASE0_ADDR),
        .BASE1_ADDR (BASE1_ADDR)
    ) u_reader (
        .clk_12_5m  (clk_12_5m),
        .rst_12_5m  (rst_12_5m),
        .cfg        (cfg),
        .rd_en      (rd_en),
        .rdata      (ram_rdata),
        .raddr      (ram_raddr),
        .tx_dval    (tx_dval),
        .tx_data    (tx_data),
        .frame_done (frame_done)
    );

    dmm_ready_tracker #(
        .SLOT_MULT     (SLOT_MULT),
        .DEFAULT_SLOT  (DEFAULT_SLOT),
        .MIN_RUN_CYCLE (MIN_RUN_CYCLE)
    ) u_tracker (
        .clk_12_5m  (clk_12_5m),
        .rst_12_5m  (rst_12_5m),
        .cfg        (cfg),
        .wr_finish  (wr_finish),
        .frame_done (frame_done),
        .dmm_empty  (dmm_empty)
    );

endmodule

`default_nettype wire

/* bench/tb_dmm_tx_model.svh */
`ifndef TB_DMM_TX_MODEL_SVH
`define TB_DMM_TX_MODEL_SVH

// ------------------------------------------------------------
// reference model, compiled inside the bench module
// ------------------------------------------------------------
localparam int          HDR_LEN      = 7;        // header words ahead of payload
localparam int          RESEND_LIMIT = 2;
localparam logic [15:0] COM_LEN      = 16'd256;
localparam logic [15:0] IO_LEN       = 16'd64;
localparam logic [15:0] OVERHEAD     = 16'd8;

// config as last written over apb
logic [15:0] ref_run_cycle;
logic [7:0]  ref_sta;
logic [2:0]  ref_port [2];     // dest port per channel
logic [7:0]  ref_ms;
logic [4:0]  ref_type;

// buffer contents per channel
logic [17:0] ref_buf [2][0:63];
int          ref_len [2];

function automatic logic is_com_type(input logic [4:0] typ);
    return (typ == 5'd2) || (typ == 5'd3) || (typ == 5'd4);   // com2, com3, mpu
endfunction

function automatic logic [4:0] random_io_type();
    logic [4:0] typ;
    typ = 5'($urandom);
    if (is_com_type(typ)) begin
        typ = typ + 5'd3;   // 2..4 moved to 5..7
    end
    return typ;
endfunction

function automatic logic [17:0] header_word(input int chn, input int k);
    logic [2:0]  port;
    logic [15:0] len;
    logic [17:0] w;
    port = ref_port[chn];
    len  = is_com_type(ref_type) ? COM_LEN - OVERHEAD : IO_LEN - OVERHEAD;
    case (k)
        0:       w = {1'b1, 1'b0, 6'd0, ref_sta, port[2:1]};    // start flag set
        1:       w = {2'b00, port[0], 12'd0, ref_ms[0], 2'b00};
        3:       w = {2'b00, ref_run_cycle};
        4:       w = {2'b00, 16'h0800};                         // data type
        6:       w = {2'b00, len};
        default: w = '0;                                        // words 2 and 5
    endcase
    return w;
endfunction

// word k of the stream, header first then payload without start flag
function automatic logic [17:0] expected_word(input int chn, input int k);
    if (k < HDR_LEN) begin
        return header_word(chn, k);
    end
    return {1'b0, ref_buf[chn][k - HDR_LEN][16:0]};
endfunction

function automatic int slot_cycles(input logic [15:0] rc);
    return (rc > MIN_RUN_CYCLE) ? int'(rc) * SLOT_MULT : DEFAULT_SLOT;
endfunction

function automatic logic offers_again(input logic [4:0] typ);
    return typ != 5'd3;   // com3 is sent once only
endfunction

`endif

/* bench/tb_dmm_tx.sv */
`default_nettype none

module tb_dmm_tx;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          SLOT_MULT     = 4;
    localparam int          DEFAULT_SLOT  = 300;
    localparam int          MIN_RUN_CYCLE = 30;
    localparam int          CLK_HALF      = 100;    // 200 ns period
    localparam int          DRV_DLY       = 20;     // input skew after the edge
    localparam logic [31:0] SEED          = 32'hfd46_d84b;

    logic                 clk_12_5m = 1'b0;
    logic                 rst_12_5m;
    logic [2:0]           paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [15:0]          pwdata;
    logic [15:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    dmm_tx_pkg::wr_port_t wr_port;
    logic [1:0]           rd_en;
    logic [1:0]           tx_dval;
    dmm_tx_pkg::word_t    tx_data;
    logic [1:0]           dmm_empty;

    string       test_name;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    int unsigned cycle = 0;    // rising edges so far

    `include "tb_dmm_tx_model.svh"

    dmm_tx_top #(
        .BASE0_ADDR    (10'd0),
        .BASE1_ADDR    (10'd512),
        .SLOT_MULT     (SLOT_MULT),
        .DEFAULT_SLOT  (DEFAULT_SLOT),
        .MIN_RUN_CYCLE (MIN_RUN_CYCLE)
    ) UUT (
        .clk_12_5m (clk_12_5m),
        .rst_12_5m (rst_12_5m),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .wr_port   (wr_port),
        .rd_en     (rd_en),
        .tx_dval   (tx_dval),
        .tx_data   (tx_data),
        .dmm_empty (dmm_empty)
    );

    always #CLK_HALF clk_12_5m = ~clk_12_5m;

    always @(posedge clk_12_5m) begin
        cycle <= cycle + 1;
    end

    // ------------------------------------------------------------
    // low level helpers
    // ------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk_12_5m);
        #DRV_DLY;    // outputs settled, inputs may change
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s, %0d errors", test_name, test_errs);
        end
    endtask

    task automatic idle_inputs();
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        wr_port = '0;
        rd_en   = 2'b00;
    endtask

    task automatic reset_dut();
        idle_inputs();
        rst_12_5m = 1'b0;
        repeat (5) next_cycle();
        rst_12_5m = 1'b1;
        next_cycle();
    endtask

    // ------------------------------------------------------------
    // apb master
    // ------------------------------------------------------------
    task automatic apb_write(input logic [2:0] addr, input logic [15:0] data);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        next_cycle();
        penable = 1'b1;
        next_cycle();    // write lands on this edge
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [2:0] addr, output logic [15:0] data, output logic err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        next_cycle();
        penable = 1'b1;
        #1;
        data = prdata;   // access phase
        err  = pslverr;
        check_val("pready in access phase", 1, pready);
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic program_cfg(input logic [15:0] rc, input logic [4:0] typ);
        ref_run_cycle = rc;
        ref_sta       = 8'($urandom);
        ref_port[0]   = 3'($urandom);
        ref_port[1]   = 3'($urandom);
        ref_ms        = 8'($urandom);
        ref_type      = typ;
        apb_write(dmm_tx_pkg::RUN_CYCLE, ref_run_cycle);
        apb_write(dmm_tx_pkg::STA_NUM, {8'd0, ref_sta});
        apb_write(dmm_tx_pkg::DST_PORTS, {9'd0, ref_port[1], 1'b0, ref_port[0]});
        apb_write(dmm_tx_pkg::MS_FLAG, {8'd0, ref_ms});
        apb_write(dmm_tx_pkg::CHN_TYPE, {11'd0, ref_type});
    endtask

    // ------------------------------------------------------------
    // frame side
    // ------------------------------------------------------------
    task automatic wait_empty(input int chn, input logic level, input int limit,
                              output int unsigned at);
        int n;
        n = 0;
        while (dmm_empty[chn] !== level && n < limit) begin
            next_cycle();
            n++;
        end
        at = cycle;
        assert (dmm_empty[chn] === level) else begin
            report_error($sformatf("dmm_empty[%0d] did not go to %0b within %0d cycles",
                                   chn, level, limit));
        end
    endtask

    task automatic hold_empty(input int chn, input int cycles);
        int   n;
        logic ok;
        ok = 1'b1;
        for (n = 0; n < cycles; n++) begin
            next_cycle();
            ok = ok & dmm_empty[chn];
        end
        assert (ok) else begin
            report_error($sformatf("dmm_empty[%0d] fell although no more offers were due", chn));
        end
    endtask

    task automatic write_frame(input int chn, input int len, output int unsigned t_fall);
        int idx;
        ref_len[chn] = len;
        for (idx = 0; idx < len; idx++) begin
            ref_buf[chn][idx] = {1'($urandom), (idx == len - 1), 16'($urandom)};  // marker last
        end
        idx = 0;
        wr_port.wr_sel   = 1'b1;
        wr_port.port_sel = chn[0];
        while (idx < len) begin
            wr_port.wr_en   = ($urandom % 4) != 0;   // odd idle cycle inside the frame
            wr_port.wr_data = ref_buf[chn][idx];
            if (wr_port.wr_en) begin
                idx++;
            end
            next_cycle();
        end
        wr_port.wr_sel = 1'b0;
        wr_port.wr_en  = 1'b0;
        wait_empty(chn, 1'b0, 8, t_fall);
    endtask

    task automatic read_frame(input int chn);
        int k;
        int total;
        total = HDR_LEN + ref_len[chn];
        check_val("tx_dval before read", 0, tx_dval);
        rd_en = 2'b01 << chn;
        for (k = 0; k < total; k++) begin
            next_cycle();
            if (k == total - 1) begin
                rd_en = 2'b00;   // marker was the last enabled cycle
            end
            check_val($sformatf("tx_dval word %0d", k), 2'b01 << chn, tx_dval);
            check_val($sformatf("tx_data word %0d", k), expected_word(chn, k), tx_data);
        end
        next_cycle();
        check_val("tx_dval after frame", 0, tx_dval);
        check_val("dmm_empty after marker", 1, dmm_empty[chn]);
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic register_test();
        logic [15:0] exp_val [5];
        logic [15:0] rd_val;
        logic        err;
        int          i;
        start_test("apb_registers");
        check_val("dmm_empty after reset", 2'b11, dmm_empty);
        check_val("tx_dval after reset", 0, tx_dval);
        check_val("tx_data after reset", 0, tx_data);
        for (i = 0; i < 5; i++) begin
            apb_read(3'(i), rd_val, err);
            check_val($sformatf("register %0d after reset", i), 0, rd_val);
        end
        program_cfg(16'($urandom), 5'($urandom));
        exp_val[0] = ref_run_cycle;
        exp_val[1] = {8'd0, ref_sta};
        exp_val[2] = {9'd0, ref_port[1], 1'b0, ref_port[0]};
        exp_val[3] = {8'd0, ref_ms};
        exp_val[4] = {11'd0, ref_type};
        for (i = 0; i < 5; i++) begin
            apb_read(3'(i), rd_val, err);
            check_val($sformatf("register %0d", i), exp_val[i], rd_val);
            check_val($sformatf("pslverr at %0d", i), 0, err);
        end
        apb_read(3'(5 + $urandom % 3), rd_val, err);   // offsets 5..7 unmapped
        check_val("pslverr unmapped", 1, err);
        finish_test();
    endtask

    task automatic frame_test(input string name, input logic [4:0] typ);
        int          chn;
        int unsigned t_fall;
        start_test(name);
        reset_dut();
        program_cfg(16'($urandom), typ);
        chn = $urandom % 2;
        write_frame(chn, 1 + $urandom % 40, t_fall);
        check_val("other channel dmm_empty", 1, dmm_empty[1 - chn]);
        read_frame(chn);
        finish_test();
    endtask

    task automatic offer_test(input string name, input logic [15:0] rc, input logic [4:0] typ);
        int          chn;
        int          slot;
        int          n;
        int unsigned t_prev;
        int unsigned t_fall;
        start_test(name);
        reset_dut();
        program_cfg(rc, typ);
        slot = slot_cycles(rc);
        chn  = $urandom % 2;
        write_frame(chn, 1 + $urandom % 40, t_prev);
        read_frame(chn);
        if (offers_again(typ)) begin
            for (n = 0; n < RESEND_LIMIT; n++) begin
                wait_empty(chn, 1'b0, slot * 3, t_fall);
                check_val($sformatf("cycles to offer %0d", n + 1), slot, t_fall - t_prev);
                t_prev = t_fall;
                read_frame(chn);   // same frame again
            end
        end
        hold_empty(chn, slot * 3);
        finish_test();
    endtask

    task automatic alternate_test();
        int          round;
        int          chn;
        int unsigned t_fall;
        start_test("alternate_channels");
        reset_dut();
        program_cfg(16'($urandom % 31), 5'($urandom));   // long default slot
        for (round = 0; round < 3; round++) begin
            for (chn = 0; chn < 2; chn++) begin
                write_frame(chn, 1 + $urandom % 40, t_fall);
            end
            for (chn = 0; chn < 2; chn++) begin
                read_frame(chn);
            end
        end
        finish_test();
    endtask

    initial begin
        void'($urandom(SEED));
        tests_run    = 0;
        tests_failed = 0;
        reset_dut();
        register_test();
        frame_test("frame_com_type", 5'(2 + $urandom % 3));
        frame_test("frame_io_type", random_io_type());
        offer_test("offer_long_cycle", 16'(31 + $urandom % 50), random_io_type());
        offer_test("offer_short_cycle", 16'($urandom % 31), random_io_type());
        offer_test("offer_com3", 16'($urandom % 31), 5'd3);
        alternate_test();
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+bench
common/dmm_tx_pkg.sv
source/dmm_cfg_regs.sv
buffer/dmm_buffer_writer.sv
buffer/dmm_frame_ram.sv
framer/dmm_frame_reader.sv
framer/dmm_ready_tracker.sv
source/dmm_tx_top.sv
bench/tb_dmm_tx.sv

/* Bender.yml */
package:
  name: dmm_tx

sources:
  - common/dmm_tx_pkg.sv
  - source/dmm_cfg_regs.sv
  - buffer/dmm_buffer_writer.sv
  - buffer/dmm_frame_ram.sv
  - framer/dmm_frame_reader.sv
  - framer/dmm_ready_tracker.sv
  - source/dmm_tx_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_dmm_tx.sv
